//--- design/isa_pkg.sv
/*
 * RV32 instruction-set definitions for the decode stage with major opcodes,
 * funct codes and the field layouts of the R, I, S and U formats.
 */
package isa_pkg;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] word_t;

  // Major opcodes kept by this stage
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37
  } opcode_e;

  ////////////////////////////////////////////////////////////////////
  // Funct codes
  ////////////////////////////////////////////////////////////////////

  // ALU functions shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Load and store sizes where bit 2 marks zero extension
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  ////////////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } insn_s_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    opcode_e     opcode;
  } insn_u_t;

  // One instruction word viewed in whichever format the opcode asks for
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_u_t u;
  } insn_u;

endpackage

//--- design/stage_pkg.sv
/*
 * Control encodings internal to the decode stage and its execute
 * interface: ALU operators, operand and immediate selects, access sizes.
 */
package stage_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_U
  } imm_sel_e;

  // Same size encoding as the data interface of the LSU
  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10
  } mem_type_e;

endpackage

//--- design/fetch_intake.sv
/*
 * Fetch intake as a four-phase receiver that captures instruction and pc,
 * holds them for the stage and closes the handshake once it is done.
 */
`timescale 1ns/1ns

module fetch_intake (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           instr_req_i,
  input  isa_pkg::word_t instr_i,
  input  isa_pkg::word_t pc_i,
  output logic           instr_ack_o,
  input  logic           insn_done_i,
  output logic           insn_valid_o,
  output isa_pkg::insn_u insn_o,
  output isa_pkg::word_t pc_o
);

  typedef enum logic [1:0] {ST_EMPTY, ST_HOLD, ST_ACK} state_e;

  state_e         state_q, state_d;
  isa_pkg::insn_u insn_q;
  isa_pkg::word_t pc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_EMPTY: if (instr_req_i) state_d = ST_HOLD;
      ST_HOLD:  if (insn_done_i) state_d = ST_ACK;
      // Wait for fetch to drop its request
      ST_ACK:   if (!instr_req_i) state_d = ST_EMPTY;
      default:  state_d = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (state_q == ST_EMPTY && instr_req_i) begin
      insn_q <= instr_i;
      pc_q   <= pc_i;
    end
  end

  assign insn_valid_o = (state_q == ST_HOLD);
  assign instr_ack_o  = (state_q == ST_ACK);
  assign insn_o       = insn_q;
  assign pc_o         = pc_q;

endmodule

//--- design/insn_decoder.sv
/*
 * Instruction decoder that forms register indices, immediates, ALU and
 * memory controls and the illegal flag for the held instruction.
 */
`timescale 1ns/1ns

module insn_decoder #(
  parameter int unsigned NumRegs = 32
) (
  input  isa_pkg::insn_u       insn_i,
  output isa_pkg::reg_addr_t   rs1_o,
  output isa_pkg::reg_addr_t   rs2_o,
  output isa_pkg::reg_addr_t   rd_o,
  output isa_pkg::word_t       imm_i_o,
  output isa_pkg::word_t       imm_s_o,
  output isa_pkg::word_t       imm_u_o,
  output stage_pkg::imm_sel_e  imm_sel_o,
  output stage_pkg::op_a_sel_e op_a_sel_o,
  output stage_pkg::op_b_sel_e op_b_sel_o,
  output stage_pkg::alu_op_e   alu_op_o,
  output logic                 rd_we_o,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output logic                 data_sign_ext_o,
  output stage_pkg::mem_type_e data_type_o,
  output logic                 illegal_o
);

  logic       use_rs1, use_rs2;
  logic       bad_insn;
  logic       bad_reg;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Register fields sit at the same bits in every format
  assign rs1_o  = insn_i.r.rs1;
  assign rs2_o  = insn_i.r.rs2;
  assign rd_o   = insn_i.r.rd;
  assign funct3 = insn_i.r.funct3;
  // For OP-IMM shifts the upper immediate bits act as funct7
  assign funct7 = insn_i.r.funct7;

  assign imm_i_o = {{20{insn_i.i.imm[11]}}, insn_i.i.imm};
  assign imm_s_o = {{20{insn_i.s.imm_hi[6]}}, insn_i.s.imm_hi, insn_i.s.imm_lo};
  assign imm_u_o = {insn_i.u.imm, 12'b0};

  ////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    imm_sel_o       = stage_pkg::IMM_I;
    op_a_sel_o      = stage_pkg::OP_A_REG_A;
    op_b_sel_o      = stage_pkg::OP_B_REG_B;
    alu_op_o        = stage_pkg::ALU_ADD;
    rd_we_o         = 1'b0;
    data_req_o      = 1'b0;
    data_we_o       = 1'b0;
    data_sign_ext_o = 1'b0;
    data_type_o     = stage_pkg::MEM_WORD;
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;
    bad_insn        = 1'b0;

    case (insn_i.r.opcode)
      isa_pkg::OPC_OP, isa_pkg::OPC_OP_IMM: begin
        rd_we_o = 1'b1;
        use_rs1 = 1'b1;
        if (insn_i.r.opcode == isa_pkg::OPC_OP) begin
          use_rs2 = 1'b1;
        end else begin
          op_b_sel_o = stage_pkg::OP_B_IMM;
        end
        case (funct3)
          isa_pkg::F3_ADD:  alu_op_o = stage_pkg::ALU_ADD;
          isa_pkg::F3_SLL:  alu_op_o = stage_pkg::ALU_SLL;
          isa_pkg::F3_SLT:  alu_op_o = stage_pkg::ALU_SLT;
          isa_pkg::F3_SLTU: alu_op_o = stage_pkg::ALU_SLTU;
          isa_pkg::F3_XOR:  alu_op_o = stage_pkg::ALU_XOR;
          isa_pkg::F3_SR:   alu_op_o = stage_pkg::ALU_SRL;
          isa_pkg::F3_OR:   alu_op_o = stage_pkg::ALU_OR;
          default:          alu_op_o = stage_pkg::ALU_AND;
        endcase
        // Alternate funct7 selects SUB and SRA
        if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_SR) begin
          alu_op_o = stage_pkg::ALU_SRA;
        end else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_ADD &&
                     use_rs2) begin
          alu_op_o = stage_pkg::ALU_SUB;
        end else if (funct7 != isa_pkg::F7_BASE &&
                     (use_rs2 || funct3 == isa_pkg::F3_SLL ||
                      funct3 == isa_pkg::F3_SR)) begin
          bad_insn = 1'b1;
        end
      end

      isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC: begin
        rd_we_o    = 1'b1;
        imm_sel_o  = stage_pkg::IMM_U;
        op_b_sel_o = stage_pkg::OP_B_IMM;
        op_a_sel_o = (insn_i.r.opcode == isa_pkg::OPC_LUI) ? stage_pkg::OP_A_ZERO
                                                           : stage_pkg::OP_A_PC;
      end

      isa_pkg::OPC_LOAD: begin
        rd_we_o         = 1'b1;
        use_rs1         = 1'b1;
        data_req_o      = 1'b1;
        op_b_sel_o      = stage_pkg::OP_B_IMM;
        data_sign_ext_o = ~funct3[2];
        case (funct3)
          isa_pkg::F3_LB, isa_pkg::F3_LBU: data_type_o = stage_pkg::MEM_BYTE;
          isa_pkg::F3_LH, isa_pkg::F3_LHU: data_type_o = stage_pkg::MEM_HALF;
          isa_pkg::F3_LW:                  data_type_o = stage_pkg::MEM_WORD;
          default:                         bad_insn    = 1'b1;
        endcase
      end

      isa_pkg::OPC_STORE: begin
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        data_req_o = 1'b1;
        data_we_o  = 1'b1;
        imm_sel_o  = stage_pkg::IMM_S;
        op_b_sel_o = stage_pkg::OP_B_IMM;
        case (funct3)
          isa_pkg::F3_SB: data_type_o = stage_pkg::MEM_BYTE;
          isa_pkg::F3_SH: data_type_o = stage_pkg::MEM_HALF;
          isa_pkg::F3_SW: data_type_o = stage_pkg::MEM_WORD;
          default:        bad_insn    = 1'b1;
        endcase
      end

      default: bad_insn = 1'b1;
    endcase
  end

  // Embedded variant has fewer registers
  assign bad_reg = (use_rs1 && rs1_o >= NumRegs) ||
                   (use_rs2 && rs2_o >= NumRegs) ||
                   (rd_we_o && rd_o >= NumRegs);

  assign illegal_o = bad_insn | bad_reg;

endmodule

//--- design/register_file.sv
/*
 * Register file with two asynchronous read ports and one write port.
 * Register 0 is hard-wired to zero.
 */
`timescale 1ns/1ns

module register_file #(
  parameter int unsigned NumRegs = 32
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  isa_pkg::reg_addr_t raddr_a_i,
  input  isa_pkg::reg_addr_t raddr_b_i,
  input  isa_pkg::reg_addr_t waddr_i,
  output isa_pkg::word_t     rdata_a_o,
  output isa_pkg::word_t     rdata_b_o,
  input  isa_pkg::word_t     wdata_i,
  input  logic               we_i
);

  isa_pkg::word_t regs_q [NumRegs];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (we_i && waddr_i != '0 && waddr_i < NumRegs) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Indices beyond the array read as zero
  assign rdata_a_o = (raddr_a_i < NumRegs) ? regs_q[raddr_a_i] : '0;
  assign rdata_b_o = (raddr_b_i < NumRegs) ? regs_q[raddr_b_i] : '0;

endmodule

//--- design/operand_select.sv
/*
 * Operand selection that picks the immediate by format and forms ALU
 * operands A and B.
 */
`timescale 1ns/1ns

module operand_select (
  input  isa_pkg::word_t       pc_i,
  input  isa_pkg::word_t       rdata_a_i,
  input  isa_pkg::word_t       rdata_b_i,
  input  isa_pkg::word_t       imm_i_i,
  input  isa_pkg::word_t       imm_s_i,
  input  isa_pkg::word_t       imm_u_i,
  input  stage_pkg::imm_sel_e  imm_sel_i,
  input  stage_pkg::op_a_sel_e op_a_sel_i,
  input  stage_pkg::op_b_sel_e op_b_sel_i,
  output isa_pkg::word_t       operand_a_o,
  output isa_pkg::word_t       operand_b_o
);

  isa_pkg::word_t imm;

  always_comb begin
    case (imm_sel_i)
      stage_pkg::IMM_S: imm = imm_s_i;
      stage_pkg::IMM_U: imm = imm_u_i;
      default:          imm = imm_i_i;
    endcase
  end

  always_comb begin
    case (op_a_sel_i)
      stage_pkg::OP_A_REG_A: operand_a_o = rdata_a_i;
      stage_pkg::OP_A_PC:    operand_a_o = pc_i;
      default:               operand_a_o = '0;
    endcase
  end

  assign operand_b_o = (op_b_sel_i == stage_pkg::OP_B_IMM) ? imm : rdata_b_i;

endmodule

//--- design/issue_ctrl.sv
/*
 * Issue control as a four-phase requester towards the execute unit.
 * It writes the result back once per instruction and reports completion.
 */
`timescale 1ns/1ns

module issue_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic insn_valid_i,
  input  logic illegal_i,
  input  logic rd_we_i,
  output logic ex_req_o,
  input  logic ex_ack_i,
  output logic rf_we_o,
  output logic insn_done_o,
  output logic illegal_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_RELEASE,
    ST_DONE
  } state_e;

  state_e state_q, state_d;
  logic   illegal_q, illegal_d;

  ////////////////////////////////////////////////////////////////////
  // Next-state logic
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    illegal_d = 1'b0;
    rf_we_o   = 1'b0;

    case (state_q)
      ST_IDLE: begin
        if (insn_valid_i) begin
          if (illegal_i) begin
            // No execute handshake so ex_ack_i stays low in release
            illegal_d = 1'b1;
            state_d   = ST_RELEASE;
          end else begin
            state_d = ST_REQUEST;
          end
        end
      end

      ST_REQUEST: begin
        if (ex_ack_i) begin
          // Only in this cycle so each instruction writes back once
          rf_we_o = rd_we_i;
          state_d = ST_RELEASE;
        end
      end

      ST_RELEASE: begin
        if (!ex_ack_i) begin
          state_d = ST_DONE;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      illegal_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      illegal_q <= illegal_d;
    end
  end

  assign ex_req_o    = (state_q == ST_REQUEST);
  assign insn_done_o = (state_q == ST_DONE);
  assign illegal_o   = illegal_q;

endmodule

//--- design/decode_stage.sv
/*
 * Decode stage top level with fetch intake, decoder, register file,
 * operand selection and issue control towards the execute unit.
 */
`timescale 1ns/1ns

module decode_stage #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Fetch side
  input  logic                 instr_req_i,
  input  isa_pkg::word_t       instr_i,
  input  isa_pkg::word_t       pc_i,
  output logic                 instr_ack_o,
  // Execute side
  output logic                 ex_req_o,
  output stage_pkg::alu_op_e   alu_op_o,
  output isa_pkg::word_t       operand_a_o,
  output isa_pkg::word_t       operand_b_o,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output stage_pkg::mem_type_e data_type_o,
  output logic                 data_sign_ext_o,
  output isa_pkg::word_t       data_wdata_o,
  input  logic                 ex_ack_i,
  input  isa_pkg::word_t       ex_result_i,
  output logic                 illegal_o
);

  logic                 insn_valid;
  logic                 insn_done;
  isa_pkg::insn_u       insn;
  isa_pkg::word_t       pc;
  isa_pkg::reg_addr_t   rs1, rs2, rd;
  isa_pkg::word_t       imm_i, imm_s, imm_u;
  stage_pkg::imm_sel_e  imm_sel;
  stage_pkg::op_a_sel_e op_a_sel;
  stage_pkg::op_b_sel_e op_b_sel;
  logic                 rd_we;
  logic                 dec_illegal;
  logic                 rf_we;
  isa_pkg::word_t       rdata_a, rdata_b;

  fetch_intake i_fetch_intake (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .instr_req_i  (instr_req_i),
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .instr_ack_o  (instr_ack_o),
    .insn_done_i  (insn_done),
    .insn_valid_o (insn_valid),
    .insn_o       (insn),
    .pc_o         (pc)
  );

  insn_decoder #(
    .NumRegs (NumRegs)
  ) i_insn_decoder (
    .insn_i          (insn),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rd_o            (rd),
    .imm_i_o         (imm_i),
    .imm_s_o         (imm_s),
    .imm_u_o         (imm_u),
    .imm_sel_o       (imm_sel),
    .op_a_sel_o      (op_a_sel),
    .op_b_sel_o      (op_b_sel),
    .alu_op_o        (alu_op_o),
    .rd_we_o         (rd_we),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_sign_ext_o (data_sign_ext_o),
    .data_type_o     (data_type_o),
    .illegal_o       (dec_illegal)
  );

  // Written with the returned execute or load result
  register_file #(
    .NumRegs (NumRegs)
  ) i_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (rd),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wdata_i   (ex_result_i),
    .we_i      (rf_we)
  );

  operand_select i_operand_select (
    .pc_i        (pc),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .imm_i_i     (imm_i),
    .imm_s_i     (imm_s),
    .imm_u_i     (imm_u),
    .imm_sel_i   (imm_sel),
    .op_a_sel_i  (op_a_sel),
    .op_b_sel_i  (op_b_sel),
    .operand_a_o (operand_a_o),
    .operand_b_o (operand_b_o)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_valid_i (insn_valid),
    .illegal_i    (dec_illegal),
    .rd_we_i      (rd_we),
    .ex_req_o     (ex_req_o),
    .ex_ack_i     (ex_ack_i),
    .rf_we_o      (rf_we),
    .insn_done_o  (insn_done),
    .illegal_o    (illegal_o)
  );

  // Store data comes straight from read port B
  assign data_wdata_o = rdata_b;

endmodule

//--- verification/decode_ref.svh
/*
 * Reference model of the decode stage that predicts the operator, operands,
 * memory controls and write-back value of one RV32 instruction.
 */
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic logic is_illegal(logic [31:0] w);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = w[14:12];
  f7 = w[31:25];
  case (w[6:0])
    isa_pkg::OPC_OP:     return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
    isa_pkg::OPC_OP_IMM: return (f3 == 3'd1 && f7 != 7'h00) ||
                                (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
    isa_pkg::OPC_LOAD:   return f3 == 3'd3 || f3 > 3'd5;
    isa_pkg::OPC_STORE:  return f3 > 3'd2;
    isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC: return 1'b0;
    default:             return 1'b1;
  endcase
endfunction

function automatic logic writes_rd(logic [31:0] w);
  return w[6:0] != isa_pkg::OPC_STORE && !is_illegal(w);
endfunction

// Everything except OP and OP-IMM adds
function automatic stage_pkg::alu_op_e alu_op_for(logic [31:0] w);
  if (w[6:0] != isa_pkg::OPC_OP && w[6:0] != isa_pkg::OPC_OP_IMM) begin
    return stage_pkg::ALU_ADD;
  end
  case (w[14:12])
    3'd0:    return (w[6:0] == isa_pkg::OPC_OP && w[30]) ? stage_pkg::ALU_SUB
                                                         : stage_pkg::ALU_ADD;
    3'd1:    return stage_pkg::ALU_SLL;
    3'd2:    return stage_pkg::ALU_SLT;
    3'd3:    return stage_pkg::ALU_SLTU;
    3'd4:    return stage_pkg::ALU_XOR;
    3'd5:    return w[30] ? stage_pkg::ALU_SRA : stage_pkg::ALU_SRL;
    3'd6:    return stage_pkg::ALU_OR;
    default: return stage_pkg::ALU_AND;
  endcase
endfunction

function automatic logic [31:0] first_operand(logic [31:0] w, logic [31:0] pc,
                                              logic [31:0] rs1_val);
  case (w[6:0])
    isa_pkg::OPC_LUI:   return '0;
    isa_pkg::OPC_AUIPC: return pc;
    default:            return rs1_val;
  endcase
endfunction

function automatic logic [31:0] second_operand(logic [31:0] w, logic [31:0] rs2_val);
  case (w[6:0])
    isa_pkg::OPC_OP:    return rs2_val;
    isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC: return {w[31:12], 12'b0};
    isa_pkg::OPC_STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
    default:            return {{20{w[31]}}, w[31:20]};
  endcase
endfunction

function automatic stage_pkg::mem_type_e access_size(logic [31:0] w);
  case (w[13:12])
    2'd0:    return stage_pkg::MEM_BYTE;
    2'd1:    return stage_pkg::MEM_HALF;
    default: return stage_pkg::MEM_WORD;
  endcase
endfunction

function automatic logic [31:0] alu_compute(stage_pkg::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b);
  case (op)
    stage_pkg::ALU_SUB:  return a - b;
    stage_pkg::ALU_SLL:  return a << b[4:0];
    stage_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
    stage_pkg::ALU_SLTU: return {31'b0, a < b};
    stage_pkg::ALU_XOR:  return a ^ b;
    stage_pkg::ALU_SRL:  return a >> b[4:0];
    stage_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
    stage_pkg::ALU_OR:   return a | b;
    stage_pkg::ALU_AND:  return a & b;
    default:             return a + b;
  endcase
endfunction

// Data memory contents scrambled from the address
function automatic logic [31:0] mem_fill(logic [31:0] addr);
  return ({addr[31:2], 2'b00} * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ mem_key;
endfunction

function automatic logic [31:0] load_value(logic [31:0] addr, stage_pkg::mem_type_e size,
                                           logic sext);
  logic [31:0] word;
  logic [15:0] half;
  logic [7:0]  byte_val;
  word     = mem_fill(addr);
  half     = addr[1] ? word[31:16] : word[15:0];
  byte_val = word[8*addr[1:0] +: 8];
  case (size)
    stage_pkg::MEM_HALF: return sext ? {{16{half[15]}}, half} : {16'b0, half};
    stage_pkg::MEM_BYTE: return sext ? {{24{byte_val[7]}}, byte_val} : {24'b0, byte_val};
    default:             return word;
  endcase
endfunction

`endif

//--- verification/tb_decode_stage.sv
/*
 * Testbench for the decode stage with fetch and execute models around the
 * DUT, a shadow register file and a reference model that predicts each issue.
 */
`timescale 1ns/1ns

module tb_decode_stage;

  localparam int unsigned NumRegs    = 32;
  localparam int unsigned NumOpImm   = 16;
  localparam int unsigned NumOp      = 16;
  localparam int unsigned NumUpper   = 6;
  localparam int unsigned NumMem     = 16;
  localparam int unsigned NumIllegal = 6;
  localparam int unsigned NumSlow    = 12;
  localparam int unsigned NumInsns   = NumOpImm + NumOp + NumUpper + NumMem + NumIllegal +
                                       NumSlow + NumRegs;
  // Run length in ns at 20 cycles per instruction plus reset
  localparam int unsigned TimeLimit  = (NumInsns * 20 + 40) * 100;

  localparam int KindOpImm = 0;
  localparam int KindOp    = 1;
  localparam int KindUpper = 2;
  localparam int KindLoad  = 3;
  localparam int KindStore = 4;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 instr_req_i;
  logic [31:0]          instr_i;
  logic [31:0]          pc_i;
  logic                 instr_ack_o;
  logic                 ex_req_o;
  stage_pkg::alu_op_e   alu_op_o;
  logic [31:0]          operand_a_o;
  logic [31:0]          operand_b_o;
  logic                 data_req_o;
  logic                 data_we_o;
  stage_pkg::mem_type_e data_type_o;
  logic                 data_sign_ext_o;
  logic [31:0]          data_wdata_o;
  logic                 ex_ack_i;
  logic [31:0]          ex_result_i;
  logic                 illegal_o;

  logic [31:0] mem_key;
  logic [31:0] shadow [NumRegs];
  string       test_name;
  logic [31:0] cur_insn;
  logic [31:0] cur_pc;
  logic        slow_fetch;
  int          issue_count;
  int          illegal_count;
  int          checks;
  int          errors;

  // Snapshot of the outputs at the start of a request
  logic        req_q;
  logic        ack_q;
  logic [31:0] held_ctrl;
  logic [31:0] held_a;
  logic [31:0] held_b;
  logic [31:0] held_wdata;

  `include "decode_ref.svh"

  decode_stage #(
    .NumRegs (NumRegs)
  ) i_decode_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_req_i     (instr_req_i),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .instr_ack_o     (instr_ack_o),
    .ex_req_o        (ex_req_o),
    .alu_op_o        (alu_op_o),
    .operand_a_o     (operand_a_o),
    .operand_b_o     (operand_b_o),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .data_type_o     (data_type_o),
    .data_sign_ext_o (data_sign_ext_o),
    .data_wdata_o    (data_wdata_o),
    .ex_ack_i        (ex_ack_i),
    .ex_result_i     (ex_result_i),
    .illegal_o       (illegal_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus generation
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] random_insn(int kind);
    logic [31:0] w;
    logic [2:0]  f3;
    w  = $urandom;
    f3 = w[14:12];
    case (kind)
      KindOpImm: begin
        w[6:0] = isa_pkg::OPC_OP_IMM;
        if (f3 == 3'd1) begin
          w[31:25] = 7'h00;
        end else if (f3 == 3'd5) begin
          w[31:25] = {1'b0, w[30], 5'b0};
        end
      end
      KindOp: begin
        w[6:0]   = isa_pkg::OPC_OP;
        w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, w[30], 5'b0} : 7'h00;
      end
      KindUpper: w[6:0] = w[5] ? isa_pkg::OPC_LUI : isa_pkg::OPC_AUIPC;
      KindLoad: begin
        w[6:0] = isa_pkg::OPC_LOAD;
        if (f3 == 3'd3 || f3 > 3'd5) begin
          w[14:12] = 3'd2;
        end
      end
      KindStore: begin
        w[6:0]   = isa_pkg::OPC_STORE;
        w[14:12] = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
      end
      default: begin
        case ($urandom_range(2))
          // Branch and system opcodes are not decoded here
          0: w[6:0] = w[4] ? 7'h63 : 7'h73;
          1: begin
            w[6:0]   = isa_pkg::OPC_OP;
            w[31:25] = 7'h01;
          end
          default: begin
            w[6:0]   = isa_pkg::OPC_OP_IMM;
            w[14:12] = 3'd1;
            w[31:25] = 7'h20;
          end
        endcase
      end
    endcase
    return w;
  endfunction

  // Fetch model for one full four-phase transfer
  task automatic send_insn(input string name, input logic [31:0] word);
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    pc            = $urandom & 32'hffff_fffc;
    test_name     = name;
    cur_insn      = word;
    cur_pc        = pc;
    issue_count   = 0;
    illegal_count = 0;
    @(posedge clk_i);
    #5;
    instr_req_i = 1'b1;
    instr_i     = word;
    pc_i        = pc;
    do @(negedge clk_i); while (!instr_ack_o);
    if (slow_fetch) begin
      repeat ($urandom_range(3)) @(posedge clk_i);
    end
    @(posedge clk_i);
    #5;
    instr_req_i = 1'b0;
    do @(negedge clk_i); while (instr_ack_o);
    check_value("illegal_o pulses", is_illegal(word), illegal_count);
    check_value("ex_req_o requests", !is_illegal(word), issue_count);
    if (writes_rd(word) && word[11:7] != 5'd0) begin
      a = first_operand(word, pc, shadow[word[19:15]]);
      b = second_operand(word, shadow[word[24:20]]);
      if (word[6:0] == isa_pkg::OPC_LOAD) begin
        result = load_value(a + b, access_size(word), !word[14]);
      end else begin
        result = alu_compute(alu_op_for(word), a, b);
      end
      shadow[word[11:7]] = result;
    end
  endtask

  task automatic compare_issue();
    logic [31:0] w;
    logic        is_mem;
    logic        is_store;
    w        = cur_insn;
    is_store = w[6:0] == isa_pkg::OPC_STORE;
    is_mem   = is_store || w[6:0] == isa_pkg::OPC_LOAD;
    check_value("alu_op_o", alu_op_for(w), alu_op_o);
    check_value("operand_a_o", first_operand(w, cur_pc, shadow[w[19:15]]), operand_a_o);
    check_value("operand_b_o", second_operand(w, shadow[w[24:20]]), operand_b_o);
    check_value("data_req_o", is_mem, data_req_o);
    if (is_mem) begin
      check_value("data_we_o", is_store, data_we_o);
      check_value("data_type_o", access_size(w), data_type_o);
      if (is_store) begin
        check_value("data_wdata_o", shadow[w[24:20]], data_wdata_o);
      end else begin
        check_value("data_sign_ext_o", !w[14], data_sign_ext_o);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Compare process and execute model
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      req_q = 1'b0;
      ack_q = 1'b0;
    end else begin
      if (ex_req_o && !req_q) begin
        issue_count++;
        compare_issue();
        held_ctrl  = {alu_op_o, data_req_o, data_we_o, data_type_o, data_sign_ext_o};
        held_a     = operand_a_o;
        held_b     = operand_b_o;
        held_wdata = data_wdata_o;
      end else if (ex_req_o) begin
        check_value("stable controls", held_ctrl,
                    {alu_op_o, data_req_o, data_we_o, data_type_o, data_sign_ext_o});
        check_value("stable operand_a_o", held_a, operand_a_o);
        check_value("stable operand_b_o", held_b, operand_b_o);
        check_value("stable data_wdata_o", held_wdata, data_wdata_o);
      end
      if (illegal_o) begin
        illegal_count++;
      end
      // Execute handshake must be closed before fetch sees its ack
      if (instr_ack_o && !ack_q) begin
        check_value("ex_ack_i at instr_ack_o", 1'b0, ex_ack_i);
      end
      req_q = ex_req_o;
      ack_q = instr_ack_o;
    end
  end

  initial begin : execute_model
    int delay;
    forever begin
      @(negedge clk_i);
      if (ex_req_o && !ex_ack_i) begin
        delay = $urandom_range(3);
        repeat (delay) @(negedge clk_i);
        @(posedge clk_i);
        #5;
        if (data_req_o && !data_we_o) begin
          ex_result_i = load_value(operand_a_o + operand_b_o, data_type_o, data_sign_ext_o);
        end else begin
          ex_result_i = alu_compute(alu_op_o, operand_a_o, operand_b_o);
        end
        ex_ack_i = 1'b1;
        do @(negedge clk_i); while (ex_req_o);
        // Slow release of the ack
        delay = $urandom_range(3);
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        #5;
        ex_ack_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(TimeLimit);
    $display("Timeout: the run did not finish within %0d ns", TimeLimit);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    // First draw seeds the run and keys the data memory
    mem_key     = $urandom(83);
    rst_ni      = 1'b0;
    instr_req_i = 1'b0;
    instr_i     = '0;
    pc_i        = '0;
    ex_ack_i    = 1'b0;
    ex_result_i = '0;
    slow_fetch  = 1'b0;
    checks      = 0;
    errors      = 0;
    test_name   = "reset";
    foreach (shadow[r]) begin
      shadow[r] = '0;
    end

    repeat (8) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("instr_ack_o", 1'b0, instr_ack_o);
    check_value("ex_req_o", 1'b0, ex_req_o);
    check_value("illegal_o", 1'b0, illegal_o);

    for (int n = 0; n < NumOpImm; n++) begin
      send_insn("op_imm", random_insn(KindOpImm));
    end
    for (int n = 0; n < NumOp; n++) begin
      send_insn("op", random_insn(KindOp));
    end
    for (int n = 0; n < NumUpper; n++) begin
      send_insn("lui_auipc", random_insn(KindUpper));
    end
    for (int n = 0; n < NumMem; n++) begin
      send_insn("load_store", random_insn(n[0] ? KindStore : KindLoad));
    end
    for (int n = 0; n < NumIllegal; n++) begin
      send_insn("illegal", random_insn(-1));
    end

    // Slow fetch on top of random execute delays
    slow_fetch = 1'b1;
    for (int n = 0; n < NumSlow; n++) begin
      send_insn("back_pressure", random_insn($urandom_range(5)));
    end
    slow_fetch = 1'b0;

    // ADDI x0, xr, 0 shows every register on operand A
    for (int r = 0; r < NumRegs; r++) begin
      send_insn("readback", {12'b0, r[4:0], 3'b000, 5'd0, isa_pkg::OPC_OP_IMM});
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+verification
design/isa_pkg.sv
design/stage_pkg.sv
design/fetch_intake.sv
design/insn_decoder.sv
design/register_file.sv
design/operand_select.sv
design/issue_ctrl.sv
design/decode_stage.sv
verification/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - design/isa_pkg.sv
  - design/stage_pkg.sv
  - design/fetch_intake.sv
  - design/insn_decoder.sv
  - design/register_file.sv
  - design/operand_select.sv
  - design/issue_ctrl.sv
  - design/decode_stage.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_decode_stage.sv
